/* rtl/cmprs_buf_pkg.sv */
////////////////////////////////////////////////////////////
// compressor page buffer bookkeeping
// page pointers, release queue depth and the records that
// pass a macroblock from the scanner to the pixel reader
////////////////////////////////////////////////////////////
package cmprs_buf_pkg;

    localparam int PAGE_PTR_W = 3; // page counter, one bit beyond the buffer page
    localparam int NUM_PAGES  = 4; // pages in the external read buffer
    localparam int REL_DEPTH  = 2; // accepted macroblocks not yet released

    typedef logic [PAGE_PTR_W-1:0]       page_ptr_t; // wraps modulo 8, low bits select the page
    typedef logic [$clog2(NUM_PAGES)-1:0] page_num_t; // physical buffer page
    typedef logic [1:0]                  page_cnt_t; // number of pages, 0 to 3

    // one macroblock as produced by the frame scanner
    typedef struct packed {
        logic [3:0] x_units;       // left column in 8-pixel units inside the tile
        page_cnt_t  last_page_ofs; // last spanned page counted from the oldest
        page_cnt_t  advance;       // pages freed once this macroblock is done
        logic       first_mb;      // first macroblock of the frame
        logic       last_mb;       // last macroblock of the frame
    } mb_desc_t;

    // macroblock start as offered to the pixel reader
    typedef struct packed {
        page_num_t               start_page;   // page holding the macroblock's left edge
        cmprs_geom_pkg::pix_x_t  macroblock_x; // left pixel relative to that page
        logic                    first_mb;     // first macroblock of the frame
        logic                    last_mb;      // last macroblock of the frame
    } mb_start_t;

endpackage

/* rtl/cmprs_geom_pkg.sv */
////////////////////////////////////////////////////////////
// compressor frame geometry
// macroblock counts, tile coordinates and the per-frame
// configuration record shared by the macroblock sequencer
////////////////////////////////////////////////////////////
package cmprs_geom_pkg;

    localparam int MB_CNT_W   = 13; // macroblock row/column counts
    localparam int PIX_X_W    = 7;  // pixel column inside a 128-pixel tile
    localparam int X_UNIT_W   = 5;  // 8-pixel columns plus a carry bit
    localparam int TILE_CODE_W = 2; // tile width selector

    typedef logic [MB_CNT_W-1:0]    mb_count_t;   // number of macroblocks minus one
    typedef logic [PIX_X_W-1:0]     pix_x_t;      // left pixel of a macroblock in its tile
    typedef logic [X_UNIT_W-1:0]    x_unit_t;     // column in units of 8 pixels
    typedef logic [TILE_CODE_W-1:0] tile_width_t; // 0:16, 1:32, 2:64, 3:128 pixels

    // configuration is held steady for the whole frame
    typedef struct packed {
        logic [4:0]  left_marg;          // left margin inside the first tile, in pixels
        mb_count_t   n_blocks_in_row_m1; // macroblocks per row minus one
        mb_count_t   n_block_rows_m1;    // macroblock rows per frame minus one
        logic [5:0]  mb_w_m1;            // macroblock width minus one, low 3 bits unused
        logic [4:0]  mb_hper;            // horizontal macroblock period, 8 or 16
        tile_width_t tile_width;         // memory tile width code
    } frame_cfg_t;

endpackage

/* rtl/cmprs_mb_buf_top.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// compressor macroblock sequencer
// frame scanner and page window feed the dispatcher
////////////////////////////////////////////////////////////
module cmprs_mb_buf_top import cmprs_geom_pkg::*, cmprs_buf_pkg::*; (
    input  logic       xclk,
    input  logic       reset_page_rd, // clears the whole sequencer
    input  frame_cfg_t cfg,           // held during a frame
    input  logic       frame_en,      // low aborts the frame
    input  logic       frame_start,   // pulse, starts a frame
    input  logic       page_ready,    // pulse per page written
    input  logic       mb_ready,      // pixel reader ready
    input  logic       mb_release,    // pulse per finished macroblock
    output logic       mb_valid,      // macroblock start offered
    output mb_start_t  mb_start,      // start record
    output logic       next_page      // pulse per freed page
);

    logic      desc_valid;
    logic      desc_ready;
    mb_desc_t  desc;
    logic      adv_valid;
    page_cnt_t adv_count;
    page_ptr_t next_valid;
    page_ptr_t oldest;
    logic      rel_full;

    mb_frame_scan u_scan (
        .xclk(xclk), .reset_page_rd(reset_page_rd), .frame_en(frame_en),
        .frame_start(frame_start), .cfg(cfg),
        .desc_valid(desc_valid), .desc(desc), .desc_ready(desc_ready)
    );

    page_window u_window (
        .xclk(xclk), .reset_page_rd(reset_page_rd), .page_ready(page_ready),
        .adv_valid(adv_valid), .adv_count(adv_count), .mb_release(mb_release),
        .next_valid(next_valid), .oldest(oldest), .rel_full(rel_full),
        .next_page(next_page)
    );

    mb_dispatch u_dispatch (
        .xclk(xclk), .reset_page_rd(reset_page_rd),
        .desc_valid(desc_valid), .desc(desc), .desc_ready(desc_ready),
        .next_valid(next_valid), .oldest(oldest), .rel_full(rel_full),
        .cfg_marg_lo(cfg.left_marg[2:0]),
        .adv_valid(adv_valid), .adv_count(adv_count),
        .mb_valid(mb_valid), .mb_start(mb_start), .mb_ready(mb_ready)
    );

endmodule

/* rtl/mb_dispatch.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// macroblock dispatcher
// waits until the buffer holds every page a descriptor
// needs, then offers the macroblock start to the reader
////////////////////////////////////////////////////////////
module mb_dispatch import cmprs_geom_pkg::*, cmprs_buf_pkg::*; (
    input  logic       xclk,
    input  logic       reset_page_rd, // clears the offer
    input  logic       desc_valid,    // descriptor from the scanner
    input  mb_desc_t   desc,
    output logic       desc_ready,    // descriptor consumed
    input  page_ptr_t  next_valid,    // first page not yet received
    input  page_ptr_t  oldest,        // oldest page in use
    input  logic       rel_full,      // release queue has no room
    input  logic [2:0] cfg_marg_lo,   // pixel part of the left margin
    output logic       adv_valid,     // start accepted, advance the window
    output page_cnt_t  adv_count,     // pages to advance
    output logic       mb_valid,      // start offered to the reader
    output mb_start_t  mb_start,      // start record
    input  logic       mb_ready       // reader takes the start
);

    page_ptr_t needed;   // last page this macroblock reads
    page_ptr_t buf_diff; // needed minus next_valid, negative when present
    logic      buf_ok;   // every needed page is in the buffer
    logic      launch;   // register a new start
    logic      xfer;     // reader accepts the start
    pix_x_t    mb_x;

    always_comb begin
        needed   = oldest + page_ptr_t'(desc.last_page_ofs);
        buf_diff = needed - next_valid;
        buf_ok   = buf_diff[PAGE_PTR_W-1]; // sign bit of the modulo-8 difference
        mb_x     = {desc.x_units, cfg_marg_lo}; // 8-pixel column plus margin pixels
    end

    assign launch = !mb_valid && desc_valid && buf_ok && !rel_full;
    assign xfer   = mb_valid && mb_ready;

    assign desc_ready = xfer;        // descriptor is retired with its start
    assign adv_valid  = xfer;
    assign adv_count  = desc.advance; // still held by the scanner during xfer

    always_ff @(posedge xclk) begin
        if (reset_page_rd)   mb_valid <= 1'b0;
        else if (launch)     mb_valid <= 1'b1;
        else if (xfer)       mb_valid <= 1'b0;
    end

    // start record is captured once and held under back-pressure
    always_ff @(posedge xclk) begin
        if (launch) begin
            mb_start.start_page   <= oldest[1:0]; // oldest page is where the macroblock begins
            mb_start.macroblock_x <= mb_x;
            mb_start.first_mb     <= desc.first_mb;
            mb_start.last_mb      <= desc.last_mb;
        end
    end

    // the pages of an offered start stay in the buffer until it is taken
    a_buf_ready: assert property (@(posedge xclk) disable iff (reset_page_rd)
        mb_valid && desc_valid |-> buf_ok);

endmodule

/* rtl/mb_frame_scan.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// macroblock frame scanner
// walks the frame row by row and forms one descriptor per
// macroblock with its tile column and page span
////////////////////////////////////////////////////////////
module mb_frame_scan import cmprs_geom_pkg::*, cmprs_buf_pkg::*; (
    input  logic       xclk,
    input  logic       reset_page_rd, // clears the scanner
    input  logic       frame_en,      // low aborts the frame
    input  logic       frame_start,   // starts a frame when idle
    input  frame_cfg_t cfg,           // frame geometry
    output logic       desc_valid,    // descriptor offered
    output mb_desc_t   desc,          // current macroblock
    input  logic       desc_ready     // dispatcher takes the descriptor
);

    typedef enum logic [1:0] {PH_IDLE, PH_CALC, PH_OFFER} scan_phase_t;

    scan_phase_t phase;
    logic [3:0]  x_units;    // column of the next macroblock inside its tile
    mb_count_t   cols_left;  // macroblocks after this one in the row
    mb_count_t   rows_left;  // rows after this one in the frame
    x_unit_t     cur_x;      // column the descriptor is formed from
    mb_count_t   cur_cols;
    mb_count_t   cur_rows;
    x_unit_t     left_x;     // first column of every row
    x_unit_t     span_end;   // last 8-pixel column covered by the macroblock
    x_unit_t     x_inc;      // start column of the following macroblock, unwrapped
    x_unit_t     w_mask;     // tile width in units minus one
    logic [2:0]  tile_sh;    // log2 of the tile width in units
    logic        last_in_row;
    logic        start_ok;   // frame start accepted
    logic        xfer;       // descriptor handed over
    mb_desc_t    new_desc;

    assign start_ok = (phase == PH_IDLE) && frame_en && frame_start;
    assign xfer     = desc_valid && desc_ready;
    assign desc_valid = (phase == PH_OFFER);

    always_comb begin
        left_x   = x_unit_t'(cfg.left_marg[4:3]);
        cur_x    = (phase == PH_IDLE) ? left_x : {1'b0, x_units}; // idle means frame start
        cur_cols = (phase == PH_IDLE) ? cfg.n_blocks_in_row_m1 : cols_left;
        cur_rows = (phase == PH_IDLE) ? cfg.n_block_rows_m1 : rows_left;
        tile_sh  = {1'b0, cfg.tile_width} + 3'd1;                // 16 pixel tile is 2 units
        w_mask   = (x_unit_t'(2) << cfg.tile_width) - x_unit_t'(1);
        span_end = cur_x + x_unit_t'(cfg.mb_w_m1[5:3]);
        x_inc    = cur_x + x_unit_t'(cfg.mb_hper[4:3]);
        last_in_row = (cur_cols == '0);

        new_desc.x_units       = cur_x[3:0];
        new_desc.last_page_ofs = page_cnt_t'(span_end >> tile_sh);
        // row end frees every page the macroblock touched
        new_desc.advance       = last_in_row ? new_desc.last_page_ofs + page_cnt_t'(1)
                                             : page_cnt_t'(x_inc >> tile_sh);
        new_desc.first_mb      = (phase == PH_IDLE);
        new_desc.last_mb       = last_in_row && (cur_rows == '0);
    end

    always_ff @(posedge xclk) begin
        if (reset_page_rd) begin
            phase     <= PH_IDLE;
            x_units   <= '0;
            cols_left <= '0;
            rows_left <= '0;
        end else if (!frame_en) begin
            phase <= PH_IDLE; // pointers in the page window survive an abort
        end else begin
            case (phase)
                PH_IDLE: if (frame_start) begin
                    phase     <= PH_OFFER;           // first descriptor is formed right away
                    x_units   <= left_x[3:0];
                    cols_left <= cfg.n_blocks_in_row_m1;
                    rows_left <= cfg.n_block_rows_m1;
                end
                PH_CALC: phase <= PH_OFFER;
                PH_OFFER: if (xfer) begin
                    phase <= desc.last_mb ? PH_IDLE : PH_CALC;
                    if (last_in_row) begin
                        x_units   <= left_x[3:0];      // new row restarts at the margin
                        cols_left <= cfg.n_blocks_in_row_m1;
                        rows_left <= rows_left - 1'b1;
                    end else begin
                        x_units   <= x_inc[3:0] & w_mask[3:0]; // column wraps into the next tile
                        cols_left <= cols_left - 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (start_ok || (phase == PH_CALC)) desc <= new_desc;
    end

    // the dispatcher builds its start record from a held descriptor
    a_desc_stable: assert property (@(posedge xclk) disable iff (reset_page_rd)
        desc_valid && !desc_ready && frame_en |=> desc_valid && $stable(desc));

endmodule

/* rtl/page_window.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// buffer page window
// tracks received and oldest pages, queues the advance of
// each started macroblock and frees pages on release
////////////////////////////////////////////////////////////
module page_window import cmprs_buf_pkg::*; (
    input  logic      xclk,
    input  logic      reset_page_rd, // clears all pointers
    input  logic      page_ready,    // one page written into the buffer
    input  logic      adv_valid,     // macroblock start accepted
    input  page_cnt_t adv_count,     // pages to advance for that macroblock
    input  logic      mb_release,    // reader done with its oldest macroblock
    output page_ptr_t next_valid,    // first page not yet received
    output page_ptr_t oldest,        // oldest page still in use
    output logic      rel_full,      // no room for another started macroblock
    output logic      next_page      // one page freed
);

    page_cnt_t                          rel_q [REL_DEPTH]; // advances waiting for release
    logic [$clog2(REL_DEPTH)-1:0]       rel_wp;
    logic [$clog2(REL_DEPTH)-1:0]       rel_rp;
    logic [$clog2(REL_DEPTH+1)-1:0]     rel_cnt;
    logic                               rel_acc;  // release taken from the queue
    page_ptr_t                          pend;     // next_page pulses still owed
    page_ptr_t                          pend_nxt;

    assign rel_acc   = mb_release && (rel_cnt != '0);
    assign rel_full  = (rel_cnt == REL_DEPTH[$clog2(REL_DEPTH+1)-1:0]);
    assign next_page = (pend != '0); // one pulse per cycle while pages are owed

    always_comb begin
        pend_nxt = pend;
        if (pend != '0) pend_nxt = pend_nxt - 1'b1;
        if (rel_acc)    pend_nxt = pend_nxt + page_ptr_t'(rel_q[rel_rp]); // overlapping releases add up
    end

    always_ff @(posedge xclk) begin
        if (reset_page_rd) begin
            next_valid <= '0;
            oldest     <= '0;
            rel_wp     <= '0;
            rel_rp     <= '0;
            rel_cnt    <= '0;
            pend       <= '0;
        end else begin
            if (page_ready) next_valid <= next_valid + 1'b1;
            if (adv_valid) begin
                oldest <= oldest + page_ptr_t'(adv_count);
                rel_wp <= rel_wp + 1'b1;
            end
            if (rel_acc) rel_rp <= rel_rp + 1'b1;
            rel_cnt <= rel_cnt + adv_valid - rel_acc;
            pend    <= pend_nxt;
        end
    end

    always_ff @(posedge xclk) begin
        if (adv_valid) rel_q[rel_wp] <= adv_count;
    end

    // the dispatcher holds off starts while the queue is full
    a_no_push_full: assert property (@(posedge xclk) disable iff (reset_page_rd)
        adv_valid |-> !rel_full);
    // the reader releases only macroblocks it has accepted
    a_no_rel_empty: assert property (@(posedge xclk) disable iff (reset_page_rd)
        mb_release |-> rel_cnt != '0);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the macroblock sequencer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_cmprs_mb_buf -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

/* tb.f */
rtl/cmprs_geom_pkg.sv
rtl/cmprs_buf_pkg.sv
rtl/mb_frame_scan.sv
rtl/page_window.sv
rtl/mb_dispatch.sv
rtl/cmprs_mb_buf_top.sv
verification/tb_cmprs_mb_buf.sv

/* verification/tb_cmprs_mb_buf.sv */
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// testbench for the macroblock sequencer
// feeds pages, takes and releases starts, and checks them
// against a geometry model over a table of frames
////////////////////////////////////////////////////////////
module tb_cmprs_mb_buf import cmprs_geom_pkg::*, cmprs_buf_pkg::*; ();

    localparam int N_CASES = 6;

    typedef struct packed {
        tile_width_t tile_width;
        logic [4:0]  left_marg;
        logic [3:0]  cols;      // macroblocks per row
        logic [3:0]  rows;      // macroblock rows
        logic [5:0]  mb_w_m1;
        logic [4:0]  mb_hper;
        logic [7:0]  pages;     // pages the whole frame frees, worked out by hand
    } tcase_t;

    logic       xclk;
    logic       reset_page_rd;
    frame_cfg_t cfg;
    logic       frame_en, frame_start, page_ready, mb_ready, mb_release;
    logic       mb_valid;
    mb_start_t  mb_start;
    logic       next_page;

    int          exp_x [$];           // model macroblock_x per macroblock
    int          exp_ofs [$];         // model last_page_ofs
    int          exp_adv [$];         // model advance
    int          rel_adv [$];         // advances of accepted macroblocks not yet released
    logic [31:0] lfsr = 32'hcf3d;
    int          run_sum = 0;         // pages advanced since reset
    int          pages_seen = 0;
    int          pages_sent = 0;
    int          freed = 0;
    int          owed = 0;            // next_page pulses still expected
    int          acc_idx = 0;
    int          acc_total = 0;
    int          rel_sent = 0;
    int          frame_freed = 0;
    int          errors = 0;
    int          case_errors = 0;
    int          failed_cases = 0;
    int          rel_timer = -1;
    int          gap = 0;
    bit          live = 0;            // drivers run once reset is over
    bit          hold_prev = 0;
    mb_start_t   start_prev;

    cmprs_mb_buf_top DUT (
        .xclk(xclk), .reset_page_rd(reset_page_rd), .cfg(cfg), .frame_en(frame_en),
        .frame_start(frame_start), .page_ready(page_ready), .mb_ready(mb_ready),
        .mb_release(mb_release), .mb_valid(mb_valid), .mb_start(mb_start),
        .next_page(next_page)
    );

    initial xclk = 1'b0;
    always #5 xclk = ~xclk;

    function automatic tcase_t get_case(int i);
        case (i)                        // tile, margin, cols, rows, width-1, period, pages
            0:       return '{2'd0, 5'd0,  4'd1, 4'd1, 6'd15, 5'd16, 8'd1};
            1:       return '{2'd0, 5'd11, 4'd3, 4'd2, 6'd15, 5'd16, 8'd8};
            2:       return '{2'd1, 5'd5,  4'd4, 4'd3, 6'd15, 5'd8,  8'd6};
            3:       return '{2'd2, 5'd26, 4'd4, 4'd3, 6'd15, 5'd16, 8'd6};
            4:       return '{2'd3, 5'd31, 4'd2, 4'd2, 6'd7,  5'd8,  8'd2};
            default: return '{2'd1, 5'd24, 4'd3, 4'd1, 6'd15, 5'd16, 8'd3};
        endcase
    endfunction

    // galois lfsr, stepped once for every bit handed out
    function automatic int take_bits(int n);
        int v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // tile columns in 8-pixel units, row by row as the frame is scanned
    task automatic build_model(tcase_t tc);
        int w;
        int x;
        int span;
        int inc;
        w = 2 << tc.tile_width;
        exp_x.delete();
        exp_ofs.delete();
        exp_adv.delete();
        for (int r = 0; r < int'(tc.rows); r++) begin
            x = tc.left_marg / 8;                              // each row restarts at the margin
            for (int c = 0; c < int'(tc.cols); c++) begin
                span = x + tc.mb_w_m1 / 8;
                inc  = x + tc.mb_hper / 8;
                exp_x.push_back(x * 8 + tc.left_marg % 8);
                exp_ofs.push_back(span / w);
                if (c == int'(tc.cols) - 1) begin
                    exp_adv.push_back(span / w + 1);           // row end frees all spanned pages
                end else begin
                    exp_adv.push_back(inc / w);
                    x = inc % w;
                end
            end
        end
    endtask

    task automatic report_value(string name, int got, int exp);
        $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        errors++;
        case_errors++;
    endtask

    task automatic report_problem(string what);
        $display("ERROR t=%0t %s", $time, what);
        errors++;
        case_errors++;
    endtask

    // monitor samples every output at the edge, before the DUT updates
    always @(posedge xclk) begin
        if (!reset_page_rd) begin
            if (hold_prev && (!mb_valid || mb_start != start_prev))
                report_problem("mb_start changed while the reader stalled it");
            hold_prev  = mb_valid && !mb_ready;
            start_prev = mb_start;
            if (mb_valid && acc_idx >= exp_x.size())
                report_problem("start offered beyond the end of the frame");
            else if (mb_valid && pages_seen <= run_sum + exp_ofs[acc_idx])
                report_problem("start offered before its last page arrived");
            if (mb_valid && mb_ready) begin
                if (acc_idx < exp_x.size()) begin
                    if (int'(mb_start.macroblock_x) != exp_x[acc_idx])
                        report_value("macroblock_x", int'(mb_start.macroblock_x),
                                     exp_x[acc_idx]);
                    if (int'(mb_start.start_page) != run_sum % 4)
                        report_value("start_page", int'(mb_start.start_page), run_sum % 4);
                    if (mb_start.first_mb != (acc_idx == 0))
                        report_value("first_mb", int'(mb_start.first_mb), int'(acc_idx == 0));
                    if (mb_start.last_mb != (acc_idx == exp_x.size() - 1))
                        report_value("last_mb", int'(mb_start.last_mb),
                                     int'(acc_idx == exp_x.size() - 1));
                    run_sum += exp_adv[acc_idx];
                    rel_adv.push_back(exp_adv[acc_idx]);
                end
                acc_idx++;                                    // extra starts are counted too
                acc_total++;
            end
            if (next_page) begin
                if (owed == 0) report_problem("next_page pulse with no release pending");
                else owed--;
                freed++;
                frame_freed++;
            end else if (owed != 0) begin
                report_problem("gap in the next_page pulses of a release");
            end
            if (mb_release && rel_adv.size() != 0) owed += rel_adv.pop_front();
            if (page_ready) pages_seen++;
        end
    end

    // page feeder and reader, driven 1 ns after the edge in a fixed order
    always @(posedge xclk) begin
        #1;
        page_ready = 1'b0;
        mb_release = 1'b0;
        if (live) begin
            if (gap > 0) begin
                gap--;
            end else if (pages_sent - freed < NUM_PAGES) begin // buffer holds 4 pages
                page_ready = 1'b1;
                pages_sent++;
                gap = take_bits(2);
            end
            mb_ready = (take_bits(2) != 0);                   // low one cycle in four
            if (rel_timer < 0 && rel_sent < acc_total) rel_timer = take_bits(3);
            if (rel_timer == 0) begin
                mb_release = 1'b1;                            // oldest accepted macroblock done
                rel_sent++;
                rel_timer = -1;
            end else if (rel_timer > 0) begin
                rel_timer--;
            end
        end
    end

    initial begin : main
        tcase_t tc;
        int     model_sum;
        reset_page_rd = 1'b1;
        cfg           = '0;
        frame_en      = 1'b0;
        frame_start   = 1'b0;
        page_ready    = 1'b0;
        mb_ready      = 1'b0;
        mb_release    = 1'b0;
        repeat (3) @(posedge xclk);
        live = 1;
        #1;
        if (mb_valid !== 1'b0 || next_page !== 1'b0) report_problem("outputs not idle in reset");
        reset_page_rd = 1'b0;
        frame_en      = 1'b1;
        for (int i = 0; i < N_CASES; i++) begin
            tc = get_case(i);
            build_model(tc);
            case_errors = 0;
            acc_idx     = 0;
            frame_freed = 0;
            model_sum   = 0;
            foreach (exp_adv[k]) model_sum += exp_adv[k];
            cfg.left_marg          = tc.left_marg;
            cfg.n_blocks_in_row_m1 = mb_count_t'(tc.cols - 1);
            cfg.n_block_rows_m1    = mb_count_t'(tc.rows - 1);
            cfg.mb_w_m1            = tc.mb_w_m1;
            cfg.mb_hper            = tc.mb_hper;
            cfg.tile_width         = tc.tile_width;
            frame_start = 1'b1;
            @(posedge xclk);
            #1;
            frame_start = 1'b0;
            do begin
                @(posedge xclk);
                #1;
            end while (acc_idx < exp_x.size() || rel_adv.size() != 0 || owed != 0);
            repeat (8) @(posedge xclk);                       // any extra start shows up here
            #1;
            if (acc_idx != int'(tc.rows) * int'(tc.cols))
                report_value("starts", acc_idx, int'(tc.rows) * int'(tc.cols));
            if (model_sum != int'(tc.pages)) report_value("model pages", model_sum, int'(tc.pages));
            if (frame_freed != model_sum) report_value("next_page count", frame_freed, model_sum);
            if (case_errors != 0) failed_cases++;
            $display("case %0d tile %0d: %0d starts, %0d pages freed, %0d errors",
                     i, tc.tile_width, acc_idx, frame_freed, case_errors);
        end
        $display("cases %0d, failed %0d, errors %0d", N_CASES, failed_cases, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // 400 cycles for every macroblock in the table
    initial begin : watchdog
        tcase_t t;
        int     mbs;
        mbs = 0;
        for (int i = 0; i < N_CASES; i++) begin
            t = get_case(i);
            mbs += int'(t.cols) * int'(t.rows);
        end
        #(mbs * 400 * 10);
        $display("timeout: the sequencer stopped making progress");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
